// File: gs_pkg.sv
/*
  shared widths, request address map and encodings of the gather-scatter tile
  imported by every design module and by the testbench
*/
package gs_pkg;

  localparam int data_width_lp = 32;
  localparam int req_addr_width_lp = 10;
  localparam int dmem_els_lp = 256;
  localparam int dmem_addr_width_lp = 8;
  localparam int len_width_lp = 9;
  localparam int src_width_lp = 4;
  localparam int wakeup_addr_width_lp = 10;
  localparam int id_els_lp = 8;
  localparam int id_width_lp = 3;

  // request word addresses
  localparam logic [req_addr_width_lp-1:0] run_addr_lp = 10'h000;
  localparam logic [req_addr_width_lp-1:0] len_addr_lp = 10'h001;
  localparam logic [req_addr_width_lp-1:0] stride_addr_lp = 10'h002;
  localparam logic [req_addr_width_lp-1:0] base_addr_lp = 10'h003;
  // data memory window is 0x100 to 0x1ff
  localparam logic [req_addr_width_lp-1:0] dmem_base_lp = 10'h100;

  localparam logic [data_width_lp-1:0] invalid_data_lp = 32'hDEADBEEF;

  // run fsm states
  localparam logic [1:0] st_idle_lp = 2'd0;
  localparam logic [1:0] st_gather_lp = 2'd1;
  localparam logic [1:0] st_scatter_lp = 2'd2;
  localparam logic [1:0] st_wakeup_lp = 2'd3;

  typedef enum logic [1:0] {
    op_load = 2'd0,
    op_store = 2'd1,
    op_wakeup = 2'd2
  } gs_op_e;

  // request data, seen as a plain word or as a run command
  typedef union packed {
    logic [data_width_lp-1:0] raw;
    struct packed {
      logic scatter_not_gather;
      logic [data_width_lp-wakeup_addr_width_lp-2:0] rsvd;
      logic [wakeup_addr_width_lp-1:0] wakeup_addr;
    } run;
  } gs_word_u;

endpackage

// File: gs_dmem.sv
/*
  local data memory of the tile, one port, synchronous read and write
  read data appears the cycle after v_i and is held until the next read
*/
`timescale 1ns/1ns

module gs_dmem import gs_pkg::*; (
  input  logic                          clk_i,
  input  logic                          v_i,
  input  logic                          w_i,
  input  logic [dmem_addr_width_lp-1:0] addr_i,
  input  logic [data_width_lp-1:0]      data_i,
  output logic [data_width_lp-1:0]      data_o
);

  logic [data_width_lp-1:0] mem_r [dmem_els_lp];
  logic [data_width_lp-1:0] data_r;

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (w_i) begin
        mem_r[addr_i] <= data_i;
      end else begin
        data_r <= mem_r[addr_i];
      end
    end
  end

  assign data_o = data_r;

endmodule

// File: gs_csr.sv
/*
  configuration registers of the engine and the remote address generator
  written from the request port while idle, read by the outbound path
*/
`timescale 1ns/1ns

module gs_csr import gs_pkg::*; (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            len_we_i,
  input  logic                            stride_we_i,
  input  logic                            base_we_i,
  input  logic                            run_we_i,
  input  gs_word_u                        req_data_i,
  input  logic [src_width_lp-1:0]         req_src_i,
  input  logic [len_width_lp-1:0]         count_i,
  input  logic                            scatter_i,
  output logic [len_width_lp-1:0]         len_o,
  output logic [data_width_lp-1:0]        remote_addr_o,
  output logic [wakeup_addr_width_lp-1:0] wakeup_addr_o,
  output logic [src_width_lp-1:0]         wakeup_tile_o
);

  logic [len_width_lp-1:0] len_r;
  logic [dmem_addr_width_lp-1:0] stride_r;
  logic [data_width_lp-1:0] base_r;
  logic [wakeup_addr_width_lp-1:0] wakeup_addr_r;
  logic [src_width_lp-1:0] wakeup_tile_r;
  logic [len_width_lp-1:0] index;
  logic [data_width_lp-1:0] offset;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      len_r <= '0;
      stride_r <= '0;
      base_r <= '0;
    end else begin
      if (len_we_i) len_r <= req_data_i.raw[len_width_lp-1:0];
      if (stride_we_i) stride_r <= req_data_i.raw[dmem_addr_width_lp-1:0];
      if (base_we_i) base_r <= req_data_i.raw;
    end
  end

  // requester and wakeup target captured with the run command
  always_ff @(posedge clk_i) begin
    if (run_we_i) begin
      wakeup_tile_r <= req_src_i;
      wakeup_addr_r <= req_data_i.run.wakeup_addr;
    end
  end

  // scatter runs one element ahead because of the prefetch
  assign index = scatter_i ? count_i - len_width_lp'(1) : count_i;
  assign offset = data_width_lp'(index) * data_width_lp'(stride_r);
  assign remote_addr_o = base_r + offset;

  assign len_o = len_r;
  assign wakeup_addr_o = wakeup_addr_r;
  assign wakeup_tile_o = wakeup_tile_r;

endmodule

// File: gs_progress_counter.sv
/*
  element index counter of a run, counting up from zero
  last_o flags the final element of the configured length
*/
`timescale 1ns/1ns

module gs_progress_counter import gs_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    clear_i,
  input  logic                    up_i,
  input  logic [len_width_lp-1:0] len_i,
  output logic [len_width_lp-1:0] count_o,
  output logic                    last_o
);

  logic [len_width_lp-1:0] count_r;

  // clear together with up starts at one
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (clear_i) begin
      count_r <= len_width_lp'(up_i);
    end else if (up_i) begin
      count_r <= count_r + len_width_lp'(1);
    end
  end

  assign count_o = count_r;
  assign last_o = (count_r == len_i - len_width_lp'(1));

endmodule

// File: gs_id_tracker.sv
/*
  tag pool for outstanding gather loads
  records the destination memory index of every tag and looks it up on return
*/
`timescale 1ns/1ns

module gs_id_tracker import gs_pkg::*; (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          alloc_yumi_i,
  input  logic [dmem_addr_width_lp-1:0] alloc_dest_i,
  output logic [id_width_lp-1:0]        alloc_id_o,
  output logic                          alloc_v_o,
  output logic                          all_free_o,
  input  logic                          ret_v_i,
  input  logic [id_width_lp-1:0]        ret_id_i,
  output logic [dmem_addr_width_lp-1:0] ret_dest_o
);

  logic [id_els_lp-1:0] free_r;
  logic [id_els_lp-1:0] free_n;
  logic [id_width_lp-1:0] lowest_free;
  logic hold_r;
  logic [id_width_lp-1:0] hold_id_r;
  logic [dmem_addr_width_lp-1:0] dest_r [id_els_lp];

  // priority pick, lowest index wins
  always_comb begin
    lowest_free = '0;
    for (int i = id_els_lp - 1; i >= 0; i--) begin
      if (free_r[i]) begin
        lowest_free = id_width_lp'(i);
      end
    end
  end

  // an offered tag sticks until it is taken, so a return of a
  // lower tag cannot change a pending load
  assign alloc_id_o = hold_r ? hold_id_r : lowest_free;
  assign alloc_v_o = |free_r;
  assign all_free_o = &free_r;

  always_comb begin
    free_n = free_r;
    if (alloc_yumi_i) begin
      free_n[alloc_id_o] = 1'b0;
    end
    if (ret_v_i) begin
      free_n[ret_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      free_r <= '1;
      hold_r <= 1'b0;
    end else begin
      free_r <= free_n;
      hold_r <= alloc_v_o & ~alloc_yumi_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_v_o & ~hold_r) begin
      hold_id_r <= lowest_free;
    end
    if (alloc_yumi_i) begin
      dest_r[alloc_id_o] <= alloc_dest_i;
    end
  end

  assign ret_dest_o = dest_r[ret_id_i];

endmodule

// File: gs_fsm.sv
/*
  run control of the engine: request decode and response, gather and
  scatter sequencing, returned load writeback and the final wakeup store
*/
`timescale 1ns/1ns

module gs_fsm import gs_pkg::*; (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // request and response
  input  logic                          req_v_i,
  input  logic                          req_we_i,
  input  logic [req_addr_width_lp-1:0]  req_addr_i,
  input  gs_word_u                      req_data_i,
  output logic                          req_yumi_o,
  output logic                          resp_v_o,
  output logic [data_width_lp-1:0]      resp_data_o,
  // outbound and return
  output logic                          out_v_o,
  output gs_op_e                        out_op_o,
  output logic [id_width_lp-1:0]        out_id_o,
  input  logic                          out_ready_i,
  input  logic                          ret_v_i,
  input  logic [data_width_lp-1:0]      ret_data_i,
  // csr
  output logic                          len_we_o,
  output logic                          stride_we_o,
  output logic                          base_we_o,
  output logic                          run_we_o,
  output logic                          scatter_o,
  // counter
  output logic                          clear_o,
  output logic                          up_o,
  input  logic [len_width_lp-1:0]       count_i,
  input  logic                          last_i,
  // tag tracker
  output logic                          alloc_yumi_o,
  input  logic [id_width_lp-1:0]        alloc_id_i,
  input  logic                          alloc_v_i,
  input  logic                          all_free_i,
  input  logic [dmem_addr_width_lp-1:0] ret_dest_i,
  // data memory
  output logic                          dmem_v_o,
  output logic                          dmem_w_o,
  output logic [dmem_addr_width_lp-1:0] dmem_addr_o,
  output logic [data_width_lp-1:0]      dmem_data_o,
  input  logic [data_width_lp-1:0]      dmem_rdata_i
);

  logic [1:0] state_r, state_n;
  logic send_zero_r, send_zero_n;
  logic send_invalid_r, send_invalid_n;
  logic send_dmem_r, send_dmem_n;
  // prefetched scatter word is the final element
  logic final_r, final_n;
  logic is_run, is_len, is_stride, is_base, is_dmem;

  assign is_run = (req_addr_i == run_addr_lp);
  assign is_len = (req_addr_i == len_addr_lp);
  assign is_stride = (req_addr_i == stride_addr_lp);
  assign is_base = (req_addr_i == base_addr_lp);
  assign is_dmem = (req_addr_i[req_addr_width_lp-1:dmem_addr_width_lp]
                    == dmem_base_lp[req_addr_width_lp-1:dmem_addr_width_lp]);

  always_comb begin
    state_n = state_r;
    final_n = final_r;
    send_zero_n = 1'b0;
    send_invalid_n = 1'b0;
    send_dmem_n = 1'b0;
    req_yumi_o = 1'b0;
    len_we_o = 1'b0;
    stride_we_o = 1'b0;
    base_we_o = 1'b0;
    run_we_o = 1'b0;
    clear_o = 1'b0;
    up_o = 1'b0;
    alloc_yumi_o = 1'b0;
    out_v_o = 1'b0;
    out_op_o = op_load;
    out_id_o = '0;
    dmem_v_o = 1'b0;
    dmem_w_o = 1'b0;
    dmem_addr_o = '0;
    dmem_data_o = '0;

    case (state_r)
      st_idle_lp: begin
        // counter rests at zero between runs
        clear_o = 1'b1;
        req_yumi_o = req_v_i;
        if (req_v_i) begin
          if (req_we_i) begin
            send_zero_n = 1'b1;
            len_we_o = is_len;
            stride_we_o = is_stride;
            base_we_o = is_base;
            if (is_run) begin
              run_we_o = 1'b1;
              final_n = last_i;
              if (req_data_i.run.scatter_not_gather) begin
                // fetch word 0 ahead of the first store
                up_o = 1'b1;
                dmem_v_o = 1'b1;
                state_n = st_scatter_lp;
              end else begin
                state_n = st_gather_lp;
              end
            end else if (is_dmem) begin
              dmem_v_o = 1'b1;
              dmem_w_o = 1'b1;
              dmem_addr_o = req_addr_i[dmem_addr_width_lp-1:0];
              dmem_data_o = req_data_i.raw;
            end
          end else if (is_dmem) begin
            send_dmem_n = 1'b1;
            dmem_v_o = 1'b1;
            dmem_addr_o = req_addr_i[dmem_addr_width_lp-1:0];
          end else begin
            send_invalid_n = 1'b1;
          end
        end
      end

      st_gather_lp: begin
        out_v_o = alloc_v_i;
        out_op_o = op_load;
        out_id_o = alloc_id_i;
        alloc_yumi_o = alloc_v_i & out_ready_i;
        up_o = alloc_yumi_o;
        if (alloc_yumi_o & last_i) begin
          state_n = st_wakeup_lp;
        end
      end

      st_scatter_lp: begin
        out_v_o = 1'b1;
        out_op_o = op_store;
        if (out_ready_i) begin
          if (final_r) begin
            state_n = st_wakeup_lp;
          end else begin
            dmem_v_o = 1'b1;
            dmem_addr_o = count_i[dmem_addr_width_lp-1:0];
            up_o = 1'b1;
            final_n = last_i;
          end
        end
      end

      default: begin
        // wakeup waits for every gather load to come back
        clear_o = 1'b1;
        out_v_o = all_free_i;
        out_op_o = op_wakeup;
        if (all_free_i & out_ready_i) begin
          state_n = st_idle_lp;
        end
      end
    endcase

    // returned loads land at the index recorded for their tag
    if (ret_v_i & ((state_r == st_gather_lp) | (state_r == st_wakeup_lp))) begin
      dmem_v_o = 1'b1;
      dmem_w_o = 1'b1;
      dmem_addr_o = ret_dest_i;
      dmem_data_o = ret_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_idle_lp;
      final_r <= 1'b0;
      send_zero_r <= 1'b0;
      send_invalid_r <= 1'b0;
      send_dmem_r <= 1'b0;
    end else begin
      state_r <= state_n;
      final_r <= final_n;
      send_zero_r <= send_zero_n;
      send_invalid_r <= send_invalid_n;
      send_dmem_r <= send_dmem_n;
    end
  end

  assign scatter_o = (state_r == st_scatter_lp);

  assign resp_v_o = send_zero_r | send_invalid_r | send_dmem_r;
  assign resp_data_o = send_dmem_r ? dmem_rdata_i
                     : send_invalid_r ? invalid_data_lp
                     : '0;

endmodule

// File: gs_engine.sv
/*
  gather-scatter engine tile, top level
  request port for memory and configuration, outbound port for remote accesses
*/
`timescale 1ns/1ns

module gs_engine import gs_pkg::*; (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         req_v_i,
  input  logic                         req_we_i,
  input  logic [req_addr_width_lp-1:0] req_addr_i,
  input  logic [data_width_lp-1:0]     req_data_i,
  input  logic [src_width_lp-1:0]      req_src_i,
  output logic                         req_yumi_o,
  output logic                         resp_v_o,
  output logic [data_width_lp-1:0]     resp_data_o,
  output logic                         out_v_o,
  output gs_op_e                       out_op_o,
  output logic [data_width_lp-1:0]     out_addr_o,
  output logic [data_width_lp-1:0]     out_data_o,
  output logic [id_width_lp-1:0]       out_id_o,
  output logic [src_width_lp-1:0]      out_tile_o,
  input  logic                         out_ready_i,
  input  logic                         ret_v_i,
  input  logic [id_width_lp-1:0]       ret_id_i,
  input  logic [data_width_lp-1:0]     ret_data_i
);

  logic len_we, stride_we, base_we, run_we, scatter;
  logic counter_clear, counter_up, last_lo;
  logic [len_width_lp-1:0] count_lo, len_lo;
  logic [data_width_lp-1:0] remote_addr_lo;
  logic [wakeup_addr_width_lp-1:0] wakeup_addr_lo;
  logic alloc_yumi, alloc_v_lo, all_free_lo;
  logic [id_width_lp-1:0] alloc_id_lo;
  logic [dmem_addr_width_lp-1:0] ret_dest_lo;
  logic dmem_v, dmem_w;
  logic [dmem_addr_width_lp-1:0] dmem_addr;
  logic [data_width_lp-1:0] dmem_wdata, dmem_rdata;

  gs_fsm fsm_i (
    .clk_i, .reset_i,
    .req_v_i, .req_we_i, .req_addr_i, .req_data_i, .req_yumi_o,
    .resp_v_o, .resp_data_o,
    .out_v_o, .out_op_o, .out_id_o, .out_ready_i,
    .ret_v_i, .ret_data_i,
    .len_we_o(len_we), .stride_we_o(stride_we), .base_we_o(base_we),
    .run_we_o(run_we), .scatter_o(scatter),
    .clear_o(counter_clear), .up_o(counter_up), .count_i(count_lo), .last_i(last_lo),
    .alloc_yumi_o(alloc_yumi), .alloc_id_i(alloc_id_lo), .alloc_v_i(alloc_v_lo),
    .all_free_i(all_free_lo), .ret_dest_i(ret_dest_lo),
    .dmem_v_o(dmem_v), .dmem_w_o(dmem_w), .dmem_addr_o(dmem_addr),
    .dmem_data_o(dmem_wdata), .dmem_rdata_i(dmem_rdata)
  );

  gs_csr csr_i (
    .clk_i, .reset_i,
    .len_we_i(len_we), .stride_we_i(stride_we), .base_we_i(base_we), .run_we_i(run_we),
    .req_data_i, .req_src_i,
    .count_i(count_lo), .scatter_i(scatter),
    .len_o(len_lo), .remote_addr_o(remote_addr_lo),
    .wakeup_addr_o(wakeup_addr_lo), .wakeup_tile_o(out_tile_o)
  );

  gs_progress_counter counter_i (
    .clk_i, .reset_i,
    .clear_i(counter_clear), .up_i(counter_up), .len_i(len_lo),
    .count_o(count_lo), .last_o(last_lo)
  );

  gs_id_tracker tracker_i (
    .clk_i, .reset_i,
    .alloc_yumi_i(alloc_yumi), .alloc_dest_i(count_lo[dmem_addr_width_lp-1:0]),
    .alloc_id_o(alloc_id_lo), .alloc_v_o(alloc_v_lo), .all_free_o(all_free_lo),
    .ret_v_i, .ret_id_i, .ret_dest_o(ret_dest_lo)
  );

  gs_dmem dmem_i (
    .clk_i, .v_i(dmem_v), .w_i(dmem_w), .addr_i(dmem_addr),
    .data_i(dmem_wdata), .data_o(dmem_rdata)
  );

  // wakeup stores 1 to the requester, element accesses use the generator
  assign out_addr_o = (out_op_o == op_wakeup) ? data_width_lp'(wakeup_addr_lo)
                                              : remote_addr_lo;
  assign out_data_o = (out_op_o == op_wakeup) ? data_width_lp'(1)
                    : (out_op_o == op_store) ? dmem_rdata
                    : '0;

endmodule

// File: gs_asserts.sv
/*
  port protocol assertions of the engine, attached to gs_engine by bind
  assert_fails counts failed assertions for the testbench to watch
*/
`timescale 1ns/1ns

module gs_asserts import gs_pkg::*; (
  input logic                         clk_i,
  input logic                         reset_i,
  input logic                         req_v_i,
  input logic                         req_we_i,
  input logic [req_addr_width_lp-1:0] req_addr_i,
  input logic                         req_yumi_o,
  input logic                         resp_v_o,
  input logic                         out_v_o,
  input logic                         out_ready_i,
  input gs_op_e                       out_op_o,
  input logic [data_width_lp-1:0]     out_addr_o,
  input logic [data_width_lp-1:0]     out_data_o,
  input logic [id_width_lp-1:0]       out_id_o,
  input logic [src_width_lp-1:0]      out_tile_o
);

  int assert_fails = 0;
  logic busy_r;
  logic req_xfer;

  assign req_xfer = req_v_i & req_yumi_o;

  // busy from an accepted run command until its wakeup transfers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
    end else if (req_xfer & req_we_i & (req_addr_i == run_addr_lp)) begin
      busy_r <= 1'b1;
    end else if (out_v_o & out_ready_i & (out_op_o == op_wakeup)) begin
      busy_r <= 1'b0;
    end
  end

  out_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (out_v_o & ~out_ready_i) |=> (out_v_o && $stable(out_op_o) && $stable(out_addr_o)
      && $stable(out_data_o) && $stable(out_id_o) && $stable(out_tile_o)))
    else begin
      assert_fails++;
      $error("outbound request changed while stalled");
    end

  resp_timing_a: assert property (@(posedge clk_i) disable iff (reset_i)
    1'b1 |=> (resp_v_o == $past(req_xfer)))
    else begin
      assert_fails++;
      $error("response valid not one cycle after a request transfer");
    end

  idle_quiet_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !busy_r |-> !out_v_o)
    else begin
      assert_fails++;
      $error("outbound valid raised while idle");
    end

endmodule

bind gs_engine gs_asserts asserts_i (
  .clk_i, .reset_i, .req_v_i, .req_we_i, .req_addr_i, .req_yumi_o, .resp_v_o,
  .out_v_o, .out_ready_i, .out_op_o, .out_addr_o, .out_data_o, .out_id_o, .out_tile_o
);

// File: gs_tb.sv
/*
  testbench of the gather-scatter engine with a remote memory model on the
  outbound port; covers request port access, a gather run and a scatter run
*/
`timescale 1ns/1ns

module gs_tb import gs_pkg::*; ();

  logic clk_i;
  logic reset_i;
  logic req_v;
  logic req_we;
  logic [req_addr_width_lp-1:0] req_addr;
  logic [data_width_lp-1:0] req_data;
  logic [src_width_lp-1:0] req_src;
  logic req_yumi;
  logic resp_v;
  logic [data_width_lp-1:0] resp_data;
  logic out_v;
  gs_op_e out_op;
  logic [data_width_lp-1:0] out_addr;
  logic [data_width_lp-1:0] out_data;
  logic [id_width_lp-1:0] out_id;
  logic [src_width_lp-1:0] out_tile;
  logic out_ready;
  logic ret_v;
  logic [id_width_lp-1:0] ret_id;
  logic [data_width_lp-1:0] ret_data;

  // run setup, written by the stimulus
  logic [31:0] exp_len, exp_stride, exp_base;
  logic [31:0] dmem_model [dmem_els_lp];
  // port watcher and remote memory state
  logic run_busy;
  logic run_scatter;
  logic [src_width_lp-1:0] run_src;
  logic [wakeup_addr_width_lp-1:0] run_wake;
  logic [31:0] elem_count;
  int wakeup_count;
  logic [id_els_lp-1:0] pend_v;
  logic [31:0] pend_data [id_els_lp];
  logic [15:0] lfsr_state;
  int cycle_count;

  gs_engine dut_i (
    .clk_i(clk_i), .reset_i(reset_i),
    .req_v_i(req_v), .req_we_i(req_we), .req_addr_i(req_addr), .req_data_i(req_data),
    .req_src_i(req_src), .req_yumi_o(req_yumi),
    .resp_v_o(resp_v), .resp_data_o(resp_data),
    .out_v_o(out_v), .out_op_o(out_op), .out_addr_o(out_addr), .out_data_o(out_data),
    .out_id_o(out_id), .out_tile_o(out_tile), .out_ready_i(out_ready),
    .ret_v_i(ret_v), .ret_id_i(ret_id), .ret_data_i(ret_data)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // remote memory contents seen by gather loads
  function automatic logic [31:0] remote_word(input logic [31:0] addr);
    return (addr ^ 32'hA5A50000) + (addr << 3);
  endfunction

  function automatic logic [31:0] fill_word(input logic [7:0] idx, input logic [7:0] salt);
    return {idx ^ salt, ~idx, idx + salt, salt ^ 8'h5a};
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [7:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = (bits << 1) | 8'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    abort_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  // one request, held until accepted; response taken the cycle after
  task automatic send_request(input logic we, input logic [9:0] addr, input logic [31:0] data,
                              input logic [3:0] src, output logic [31:0] resp);
    @(posedge clk_i);
    #1;
    req_v = 1'b1;
    req_we = we;
    req_addr = addr;
    req_data = data;
    req_src = src;
    @(negedge clk_i);
    while (!req_yumi) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    req_v = 1'b0;
    if (we && (addr[9:8] == 2'b01)) dmem_model[addr[7:0]] = data;
    @(negedge clk_i);
    if (!resp_v) report_error("no response in the cycle after the request was accepted");
    resp = resp_data;
  endtask

  task automatic load_and_check(input string name, input logic [9:0] addr,
                                input logic [31:0] expected);
    logic [31:0] resp;
    send_request(1'b0, addr, 32'd0, 4'h1, resp);
    check_value(name, expected, resp);
  endtask

  task automatic store_and_check(input logic [9:0] addr, input logic [31:0] data);
    logic [31:0] resp;
    send_request(1'b1, addr, data, 4'h1, resp);
    check_value("store response", 32'd0, resp);
  endtask

  task automatic configure(input logic [31:0] len, input logic [31:0] stride,
                           input logic [31:0] base);
    exp_len = len;
    exp_stride = stride;
    exp_base = base;
    store_and_check(len_addr_lp, len);
    store_and_check(stride_addr_lp, stride);
    store_and_check(base_addr_lp, base);
  endtask

  task automatic run_engine(input logic scatter, input logic [9:0] wake,
                            input logic [3:0] src, input logic [31:0] word0);
    gs_word_u cmd;
    logic [31:0] resp;
    int prior;
    cmd.raw = '0;
    cmd.run.scatter_not_gather = scatter;
    cmd.run.wakeup_addr = wake;
    prior = wakeup_count;
    send_request(1'b1, run_addr_lp, cmd.raw, src, resp);
    check_value("run response", 32'd0, resp);
    // stalls until the wakeup has gone out
    send_request(1'b0, dmem_base_lp, 32'd0, src, resp);
    check_value("word 0 after run", word0, resp);
    check_value("wakeups per run", 32'(prior + 1), 32'(wakeup_count));
  endtask

  // checks every transfer against the run setup, sampled mid-cycle
  task automatic watch_ports();
    if (dut_i.asserts_i.assert_fails != 0) report_error("a port protocol assertion failed");
    if (run_busy && req_yumi) report_error("request accepted while a run was busy");
    if (req_v && req_yumi && req_we && (req_addr == run_addr_lp)) begin
      run_busy = 1'b1;
      run_scatter = req_data[data_width_lp-1];
      run_src = req_src;
      run_wake = req_data[wakeup_addr_width_lp-1:0];
      elem_count = '0;
    end
    if (out_v && out_ready) begin
      case (out_op)
        op_load: begin
          if (run_scatter) report_error("load issued during a scatter run");
          check_value("gather load address", exp_base + elem_count * exp_stride, out_addr);
          if (pend_v[out_id]) report_error("load tag reused while still outstanding");
          pend_v[out_id] = 1'b1;
          pend_data[out_id] = remote_word(out_addr);
          elem_count = elem_count + 32'd1;
        end
        op_store: begin
          if (!run_scatter) report_error("store issued during a gather run");
          check_value("scatter store address", exp_base + elem_count * exp_stride, out_addr);
          check_value("scatter store data", dmem_model[elem_count[7:0]], out_data);
          elem_count = elem_count + 32'd1;
        end
        default: begin
          check_value("wakeup data", 32'd1, out_data);
          check_value("wakeup tile", 32'(run_src), 32'(out_tile));
          check_value("wakeup address", 32'(run_wake), out_addr);
          check_value("elements before wakeup", exp_len, elem_count);
          if (pend_v != '0) report_error("wakeup sent while gather loads were outstanding");
          run_busy = 1'b0;
          wakeup_count++;
        end
      endcase
    end
  endtask

  // remote side: random ready, delayed and reordered load returns
  initial begin
    logic [7:0] r;
    logic [id_width_lp-1:0] tag;
    out_ready = 1'b0;
    ret_v = 1'b0;
    ret_id = '0;
    ret_data = '0;
    lfsr_state = 16'd89;
    run_busy = 1'b0;
    run_scatter = 1'b0;
    run_src = '0;
    run_wake = '0;
    elem_count = '0;
    wakeup_count = 0;
    pend_v = '0;
    forever begin
      @(posedge clk_i);
      #1;
      take_bits(2, r);
      out_ready = ~reset_i & (r[1:0] != 2'b00);
      ret_v = 1'b0;
      take_bits(1, r);
      if (r[0] && (pend_v != '0)) begin
        take_bits(3, r);
        tag = r[2:0];
        // first pending tag at or after a random start
        repeat (id_els_lp) begin
          if (!ret_v && pend_v[tag]) begin
            ret_v = 1'b1;
            ret_id = tag;
            ret_data = pend_data[tag];
            pend_v[tag] = 1'b0;
          end
          tag = tag + id_width_lp'(1);
        end
      end
      @(negedge clk_i);
      watch_ports();
    end
  end

  // whole test needs a few hundred cycles, so 20000 is far beyond any healthy run
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk_i);
      cycle_count++;
      if (cycle_count >= 20000) report_error("timeout, the run did not finish in time");
    end
  end

  initial begin
    logic [7:0] idx;
    reset_i = 1'b1;
    req_v = 1'b0;
    req_we = 1'b0;
    req_addr = '0;
    req_data = '0;
    req_src = '0;
    exp_len = '0;
    exp_stride = '0;
    exp_base = '0;
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // data memory stores, then loads back
    for (int i = 0; i < 16; i++) begin
      idx = 8'(i * 37 + 5);
      store_and_check(dmem_base_lp | 10'(idx), fill_word(idx, 8'h3c));
    end
    for (int i = 0; i < 16; i++) begin
      idx = 8'(i * 37 + 5);
      load_and_check("data memory load", dmem_base_lp | 10'(idx), fill_word(idx, 8'h3c));
    end

    // config and unmapped loads
    load_and_check("run register load", run_addr_lp, 32'hDEADBEEF);
    load_and_check("length register load", len_addr_lp, 32'hDEADBEEF);
    load_and_check("stride register load", stride_addr_lp, 32'hDEADBEEF);
    load_and_check("base register load", base_addr_lp, 32'hDEADBEEF);
    load_and_check("unmapped load", 10'h0c0, 32'hDEADBEEF);
    load_and_check("unmapped high load", 10'h3ff, 32'hDEADBEEF);
    store_and_check(10'h1a5, fill_word(8'ha5, 8'h77));
    store_and_check(10'h2a5, 32'hFFFF0000);
    store_and_check(10'h0a5, 32'h0000FFFF);
    load_and_check("word after unmapped stores", 10'h1a5, fill_word(8'ha5, 8'h77));

    // gather of 12 elements
    configure(32'd12, 32'd3, 32'h40);
    run_engine(1'b0, 10'h155, 4'h6, remote_word(32'h40));
    for (int i = 0; i < 12; i++) begin
      load_and_check("gathered word", dmem_base_lp | 10'(i),
                     remote_word(32'h40 + 32'(i) * 32'd3));
    end

    // scatter of 10 preloaded words
    for (int i = 0; i < 10; i++) begin
      store_and_check(dmem_base_lp | 10'(i), fill_word(8'(i), 8'h91));
    end
    configure(32'd10, 32'd5, 32'h2000);
    run_engine(1'b1, 10'h2c4, 4'h9, fill_word(8'd0, 8'h91));

    repeat (4) @(posedge clk_i);
    if (dut_i.asserts_i.assert_fails != 0) begin
      report_error("port protocol assertions failed");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// File: project.f
gs_pkg.sv
gs_dmem.sv
gs_csr.sv
gs_progress_counter.sv
gs_id_tracker.sv
gs_fsm.sv
gs_engine.sv
gs_asserts.sv
gs_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the engine testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module gs_tb -f project.f -o gs_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running past assertion errors so the testbench reports them
out=$(./obj_dir/gs_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
  exit 0
else
  exit 1
fi
